//--- hdl/deoxys_settings.svh
`ifndef DEOXYS_SETTINGS_SVH
`define DEOXYS_SETTINGS_SVH

// Rounds after the initial tweakey addition
`define DEOXYS_ROUNDS 16

// First round constant
`define DEOXYS_RCON_INIT 8'h2f

// Reduction byte when the round constant is doubled
`define DEOXYS_RCON_POLY 8'h1b

`endif

//--- hdl/deoxys_pkg.sv
package deoxys_pkg;

   // Cipher state, subkey or one tweakey part
   // Byte 15 is the top byte and row 0 the top 32 bits
   typedef logic [127:0] block_t;

   // One state byte or a round constant
   typedef logic [7:0] byte_t;

   // One row of the state
   typedef logic [31:0] row_t;

   // Round number from 0 to 16
   typedef logic [4:0] round_idx_t;

   // Top level control
   typedef enum logic {
      IDLE,
      RUN
   } ctrl_state_t;

endpackage

//--- hdl/aes_sbox.sv
`timescale 1ns/1ps

module aes_sbox import deoxys_pkg::*; (
   input  byte_t in_byte,
   output byte_t out_byte
);

   // Standard AES forward S-box indexed by the input byte
   localparam byte_t sbox_table [256] = '{
      8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
      8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
      8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
      8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
      8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
      8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
      8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
      8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
      8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
      8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
      8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
      8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
      8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
      8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
      8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
      8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
      8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
      8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
      8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
      8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
      8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
      8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
      8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
      8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
      8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
      8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
      8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
      8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
      8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
      8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
      8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
      8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
   };

   assign out_byte = sbox_table[in_byte];

endmodule

//--- hdl/deoxys_round.sv
`timescale 1ns/1ps

module deoxys_round import deoxys_pkg::*; (
   input  block_t state_in,
   input  block_t round_key,
   output block_t state_out
);

   block_t sub_bytes;
   row_t   sub_row [4];
   row_t   shr [4];
   row_t   x2 [4];
   row_t   x3 [4];
   row_t   mix [4];

   // Doubling in GF(2^8) on each byte of a row
   function automatic row_t xtime_row(row_t r);
      row_t  d;
      byte_t b;
      for (int k = 0; k < 4; k++) begin
         b = r[8*k +: 8];
         d[8*k +: 8] = {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
      end
      return d;
   endfunction

   // Left rotation by n bytes
   function automatic row_t rot_row(row_t r, int n);
      logic [63:0] rr;
      rr = {r, r} >> (32 - 8 * n);
      return rr[31:0];
   endfunction

   genvar i;

   // SubBytes
   for (i = 0; i < 16; i++) begin : g_sbox
      aes_sbox i_aes_sbox (
         .in_byte  (state_in[8*i +: 8]),
         .out_byte (sub_bytes[8*i +: 8])
      );
   end

   for (i = 0; i < 4; i++) begin : g_rows
      assign sub_row[i] = sub_bytes[127 - 32*i -: 32];

      // ShiftRows moves row i left by i bytes
      assign shr[i] = rot_row(sub_row[i], i);

      assign x2[i] = xtime_row(shr[i]);
      assign x3[i] = x2[i] ^ shr[i];
   end

   // MixColumns works across rows with the byte lanes as columns
   // Circulant matrix rows are 2 3 1 1 rotated
   for (i = 0; i < 4; i++) begin : g_mix
      assign mix[i] = x2[i] ^ x3[(i + 1) % 4] ^ shr[(i + 2) % 4] ^ shr[(i + 3) % 4];
   end

   // AddRoundTweakey
   assign state_out = {mix[0], mix[1], mix[2], mix[3]} ^ round_key;

endmodule

//--- hdl/tweakey_schedule.sv
`timescale 1ns/1ps
`include "deoxys_settings.svh"

module tweakey_schedule import deoxys_pkg::*; (
   input  logic   clk,
   input  logic   rst_n,
   input  logic   load,
   input  logic   step,
   input  block_t counter,
   input  block_t tweak,
   input  block_t key,
   output block_t subkey
);

   // Byte permutation h where output byte j takes input byte h_src[j]
   localparam int h_src [16] = '{6, 7, 4, 5, 9, 10, 11, 8, 12, 13, 14, 15, 3, 0, 1, 2};

   block_t tk1;
   block_t tk2;
   block_t tk3;
   byte_t  rc;

   block_t tk1_next;
   block_t tk2_next;
   block_t tk3_next;
   byte_t  rc_next;

   function automatic block_t h_perm(block_t b);
      block_t p;
      for (int j = 0; j < 16; j++) begin
         p[8*j +: 8] = b[8*h_src[j] +: 8];
      end
      return p;
   endfunction

   // TK2 byte LFSR shifting left with feedback from bits 7 and 5
   function automatic block_t tk2_lfsr(block_t b);
      block_t p;
      for (int j = 0; j < 16; j++) begin
         p[8*j +: 8] = {b[8*j +: 7], b[8*j + 7] ^ b[8*j + 5]};
      end
      return p;
   endfunction

   // TK3 byte LFSR shifting right with feedback from bits 0 and 6
   function automatic block_t tk3_lfsr(block_t b);
      block_t p;
      for (int j = 0; j < 16; j++) begin
         p[8*j +: 8] = {b[8*j] ^ b[8*j + 6], b[8*j + 1 +: 7]};
      end
      return p;
   endfunction

   function automatic byte_t rc_double(byte_t b);
      byte_t poly;
      poly = `DEOXYS_RCON_POLY;
      return {b[6:0], 1'b0} ^ (b[7] ? poly : 8'h00);
   endfunction

   // Each row carries 1, 2, 4 or 8, then RC, then two zero bytes
   function automatic block_t const_word(byte_t c);
      block_t w;
      row_t   r;
      for (int k = 0; k < 4; k++) begin
         r = {byte_t'(1 << k), c, 16'h0000};
         w[127 - 32*k -: 32] = r;
      end
      return w;
   endfunction

   always_comb begin
      tk1_next = tk1;
      tk2_next = tk2;
      tk3_next = tk3;
      rc_next  = rc;
      if (load) begin
         tk1_next = counter;
         tk2_next = tweak;
         tk3_next = key;
         rc_next  = `DEOXYS_RCON_INIT;
      end else if (step) begin
         tk1_next = h_perm(tk1);
         tk2_next = tk2_lfsr(h_perm(tk2));
         tk3_next = tk3_lfsr(h_perm(tk3));
         rc_next  = rc_double(rc);
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         tk1 <= '0;
         tk2 <= '0;
         tk3 <= '0;
         rc  <= `DEOXYS_RCON_INIT;
      end else begin
         tk1 <= tk1_next;
         tk2 <= tk2_next;
         tk3 <= tk3_next;
         rc  <= rc_next;
      end
   end

   // Subkey of the tweakey being written on this edge, so the
   // load edge already sees subkey 0 and round k sees subkey k
   assign subkey = tk1_next ^ tk2_next ^ tk3_next ^ const_word(rc_next);

endmodule

//--- hdl/deoxys_bc.sv
`timescale 1ns/1ps
`include "deoxys_settings.svh"

module deoxys_bc import deoxys_pkg::*; (
   input  logic   clk,
   input  logic   rst_n,
   input  logic   start,
   input  block_t plaintext,
   input  block_t counter,
   input  block_t tweak,
   input  block_t key,
   output block_t ciphertext,
   output logic   busy,
   output logic   done
);

   ctrl_state_t ctrl;
   round_idx_t  round_cnt;
   block_t      cipher_state;
   block_t      subkey;
   block_t      round_out;
   logic        accept;
   logic        last_round;

   assign busy       = (ctrl == RUN);
   assign accept     = start && !busy;
   assign last_round = busy && (round_cnt == round_idx_t'(`DEOXYS_ROUNDS));

   tweakey_schedule i_tweakey_schedule (
      .clk     (clk),
      .rst_n   (rst_n),
      .load    (accept),
      .step    (busy),
      .counter (counter),
      .tweak   (tweak),
      .key     (key),
      .subkey  (subkey)
   );

   deoxys_round i_deoxys_round (
      .state_in  (cipher_state),
      .round_key (subkey),
      .state_out (round_out)
   );

   // round_cnt holds the number of the round done on the next edge
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ctrl      <= IDLE;
         round_cnt <= '0;
         done      <= 1'b0;
      end else begin
         done <= last_round;
         case (ctrl)
            IDLE: begin
               if (start) begin
                  ctrl      <= RUN;
                  round_cnt <= round_idx_t'(1);
               end
            end
            RUN: begin
               if (last_round) begin
                  ctrl <= IDLE;
               end else begin
                  round_cnt <= round_cnt + 1'b1;
               end
            end
            default: ctrl <= IDLE;
         endcase
      end
   end

   // Whitening on the accepting edge, then one round per edge
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         cipher_state <= '0;
      end else if (accept) begin
         cipher_state <= plaintext ^ subkey;
      end else if (busy) begin
         cipher_state <= round_out;
      end
   end

   // Held after the last round until the next accepted start
   assign ciphertext = cipher_state;

endmodule

//--- tests/deoxys_checker.sv
`timescale 1ns/1ps
`include "deoxys_settings.svh"

module deoxys_checker import deoxys_pkg::*; (
   input  logic   clk,
   input  logic   rst_n,
   input  logic   start,
   input  block_t plaintext,
   input  block_t counter,
   input  block_t tweak,
   input  block_t key,
   input  block_t ciphertext,
   input  logic   busy,
   input  logic   done,
   output int     errors,
   output int     blocks_checked,
   output int     blocks_pending
);

   // Tweakey permutation as source bytes for output bytes 15 down to 0
   localparam int perm_src [16] = '{2, 1, 0, 3, 15, 14, 13, 12, 8, 11, 10, 9, 5, 4, 7, 6};

   byte_t  sbox_model [256];
   block_t exp_q [$];
   int     due_q [$];
   block_t held_value;
   logic   held_valid;
   int     cycle;

   function automatic byte_t gf_mul(byte_t a, byte_t b);
      byte_t p;
      logic  hi;
      p = 8'h00;
      for (int i = 0; i < 8; i++) begin
         if (b[0])
            p = p ^ a;
         hi = a[7];
         a = {a[6:0], 1'b0} ^ (hi ? 8'h1b : 8'h00);
         b = b >> 1;
      end
      return p;
   endfunction

   // a^254, which is the inverse for nonzero a and 0 for 0
   function automatic byte_t gf_inv(byte_t a);
      byte_t r;
      r = 8'h01;
      for (int i = 7; i >= 0; i--) begin
         r = gf_mul(r, r);
         if (i != 0)
            r = gf_mul(r, a);
      end
      return r;
   endfunction

   function automatic byte_t rotl8(byte_t x, int n);
      logic [15:0] xx;
      xx = {x, x} >> (8 - n);
      return xx[7:0];
   endfunction

   function automatic block_t model_round(block_t s);
      byte_t  a [4][4];
      byte_t  t [4][4];
      block_t o;
      for (int r = 0; r < 4; r++)
         for (int c = 0; c < 4; c++)
            a[r][c] = sbox_model[s[127 - 32*r - 8*c -: 8]];
      for (int r = 0; r < 4; r++)
         for (int c = 0; c < 4; c++)
            t[r][c] = a[r][(c + r) % 4];
      for (int c = 0; c < 4; c++)
         for (int r = 0; r < 4; r++)
            o[127 - 32*r - 8*c -: 8] = gf_mul(8'h02, t[r][c]) ^ gf_mul(8'h03, t[(r+1)%4][c])
                                     ^ t[(r+2)%4][c] ^ t[(r+3)%4][c];
      return o;
   endfunction

   function automatic block_t permute(block_t b);
      block_t p;
      for (int i = 0; i < 16; i++)
         p[8*(15 - i) +: 8] = b[8*perm_src[i] +: 8];
      return p;
   endfunction

   // which = 2 for the TK2 byte update, 3 for TK3
   function automatic block_t byte_update(block_t b, int which);
      byte_t x;
      for (int j = 0; j < 16; j++) begin
         x = b[8*j +: 8];
         if (which == 2)
            b[8*j +: 8] = {x[6:0], x[7] ^ x[5]};
         else
            b[8*j +: 8] = {x[0] ^ x[6], x[7:1]};
      end
      return b;
   endfunction

   function automatic block_t model_subkey(block_t t1, block_t t2, block_t t3, byte_t rc);
      block_t k;
      k = t1 ^ t2 ^ t3;
      for (int r = 0; r < 4; r++) begin
         k[127 - 32*r -: 8] = k[127 - 32*r -: 8] ^ byte_t'(1 << r);
         k[119 - 32*r -: 8] = k[119 - 32*r -: 8] ^ rc;
      end
      return k;
   endfunction

   function automatic block_t encrypt(block_t pt, block_t t1, block_t t2, block_t t3);
      block_t s;
      byte_t  rc;
      byte_t  poly;
      poly = `DEOXYS_RCON_POLY;
      rc = `DEOXYS_RCON_INIT;
      s = pt ^ model_subkey(t1, t2, t3, rc);
      for (int i = 1; i <= `DEOXYS_ROUNDS; i++) begin
         t1 = permute(t1);
         t2 = byte_update(permute(t2), 2);
         t3 = byte_update(permute(t3), 3);
         rc = {rc[6:0], 1'b0} ^ (rc[7] ? poly : 8'h00);
         s = model_round(s) ^ model_subkey(t1, t2, t3, rc);
      end
      return s;
   endfunction

   task automatic report_mismatch(string name, block_t expected, block_t actual);
      errors++;
      $display("CHECK FAILED t=%0t %s expected %0h actual %0h", $time, name, expected, actual);
   endtask

   task automatic report_problem(string msg);
      errors++;
      $display("t=%0t %s", $time, msg);
   endtask

   initial begin
      errors = 0;
      blocks_checked = 0;
      blocks_pending = 0;
      held_valid = 1'b0;
      cycle = 0;
      for (int i = 0; i < 256; i++) begin
         sbox_model[i] = gf_inv(byte_t'(i));
         sbox_model[i] = sbox_model[i] ^ rotl8(sbox_model[i], 1) ^ rotl8(sbox_model[i], 2)
                       ^ rotl8(sbox_model[i], 3) ^ rotl8(sbox_model[i], 4) ^ 8'h63;
      end
   end

   // Outputs and inputs are both stable at the falling edge
   always @(negedge clk) begin
      block_t exp_ct;
      int     due;
      cycle++;
      if (!rst_n) begin
         if (busy !== 1'b0)
            report_mismatch("busy", '0, block_t'(busy));
         if (done !== 1'b0)
            report_mismatch("done", '0, block_t'(done));
         if (ciphertext !== '0)
            report_mismatch("ciphertext", '0, ciphertext);
         exp_q.delete();
         due_q.delete();
         held_valid = 1'b0;
      end else begin
         if (done) begin
            if (exp_q.size() == 0) begin
               report_problem("done pulsed with no block in flight");
            end else begin
               exp_ct = exp_q.pop_front();
               due = due_q.pop_front();
               if (cycle != due)
                  report_mismatch("done cycle", block_t'(due), block_t'(cycle));
               if (ciphertext !== exp_ct)
                  report_mismatch("ciphertext", exp_ct, ciphertext);
               blocks_checked++;
            end
            held_value = ciphertext;
            held_valid = 1'b1;
         end else begin
            if (due_q.size() > 0 && cycle > due_q[0]) begin
               report_problem("done missing for an accepted block");
               void'(exp_q.pop_front());
               void'(due_q.pop_front());
            end
            if (held_valid && ciphertext !== held_value) begin
               report_mismatch("ciphertext", held_value, ciphertext);
               held_value = ciphertext;
            end
         end
         if (busy !== (exp_q.size() != 0))
            report_mismatch("busy", block_t'(exp_q.size() != 0), block_t'(busy));
         // Accepted on the coming rising edge
         if (start && !busy) begin
            exp_q.push_back(encrypt(plaintext, counter, tweak, key));
            due_q.push_back(cycle + `DEOXYS_ROUNDS + 1);
            held_valid = 1'b0;
         end
      end
      blocks_pending = exp_q.size();
   end

endmodule

//--- tests/deoxys_props.sv
`timescale 1ns/1ps
`include "deoxys_settings.svh"

module deoxys_props (
   input logic clk,
   input logic rst_n,
   input logic start,
   input logic busy,
   input logic done
);

   logic accept;
   int   fail_count = 0;

   assign accept = start && !busy;

   done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
      else begin
         fail_count++;
         $error("done stayed high for more than one cycle");
      end

   // Rounds run on the edges after the accepting one and done shows on the edge after that
   done_latency: assert property (@(posedge clk) disable iff (!rst_n)
      accept |=> !done [*`DEOXYS_ROUNDS] ##1 done)
      else begin
         fail_count++;
         $error("done did not come the round count after an accepted start");
      end

   quiet_in_reset: assert property (@(posedge clk) !rst_n |=> !busy && !done)
      else begin
         fail_count++;
         $error("busy or done high after a reset edge");
      end

endmodule

bind deoxys_bc deoxys_props i_deoxys_props (
   .clk   (clk),
   .rst_n (rst_n),
   .start (start),
   .busy  (busy),
   .done  (done)
);

//--- tests/deoxys_bc_tb.sv
`timescale 1ns/1ps
`include "deoxys_settings.svh"

module deoxys_bc_tb import deoxys_pkg::*; ();

   localparam int clk_half = 10;
   localparam int stim_delay = 2;
   localparam int num_blocks = 46;
   localparam int timeout_cycles = num_blocks * (`DEOXYS_ROUNDS + 8) + 50;
   localparam logic [31:0] lfsr_taps = 32'h80200003;

   logic   clk;
   logic   rst_n;
   logic   start;
   block_t plaintext;
   block_t counter;
   block_t tweak;
   block_t key;
   block_t ciphertext;
   logic   busy;
   logic   done;

   int errors;
   int blocks_checked;
   int blocks_pending;
   int tb_errors = 0;
   int tests_run = 0;
   int errors_before = 0;
   int cycle_count;
   logic [31:0] lfsr_state = 32'd78103;

   deoxys_bc i_deoxys_bc (
      .clk        (clk),
      .rst_n      (rst_n),
      .start      (start),
      .plaintext  (plaintext),
      .counter    (counter),
      .tweak      (tweak),
      .key        (key),
      .ciphertext (ciphertext),
      .busy       (busy),
      .done       (done)
   );

   deoxys_checker i_deoxys_checker (
      .clk            (clk),
      .rst_n          (rst_n),
      .start          (start),
      .plaintext      (plaintext),
      .counter        (counter),
      .tweak          (tweak),
      .key            (key),
      .ciphertext     (ciphertext),
      .busy           (busy),
      .done           (done),
      .errors         (errors),
      .blocks_checked (blocks_checked),
      .blocks_pending (blocks_pending)
   );

   initial begin
      clk = 1'b0;
      forever #clk_half clk = ~clk;
   end

   initial begin
      cycle_count = 0;
      while (cycle_count < timeout_cycles) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("timeout after %0d cycles, the run did not finish", cycle_count);
      $display(">>> FAIL");
      $finish;
   end

   // Galois LFSR with one step per bit
   function automatic logic next_random_bit();
      logic b;
      b = lfsr_state[0];
      lfsr_state = (lfsr_state >> 1) ^ (b ? lfsr_taps : 32'h0);
      return b;
   endfunction

   function automatic block_t random_block();
      block_t v;
      for (int i = 0; i < 128; i++)
         v = {v[126:0], next_random_bit()};
      return v;
   endfunction

   function automatic int random_value(int nbits);
      int v;
      v = 0;
      for (int i = 0; i < nbits; i++)
         v = (v << 1) | int'(next_random_bit());
      return v;
   endfunction

   function automatic int total_errors();
      return errors + tb_errors + i_deoxys_bc.i_deoxys_props.fail_count;
   endfunction

   task automatic apply_reset();
      rst_n = 1'b0;
      repeat (3) @(posedge clk);
      #stim_delay rst_n = 1'b1;
   endtask

   // Data inputs wander while start is low
   task automatic idle_cycles(int n);
      repeat (n) begin
         @(posedge clk);
         #stim_delay;
         start = 1'b0;
         plaintext = random_block();
         counter = random_block();
         tweak = random_block();
         key = random_block();
      end
   endtask

   task automatic launch(block_t pt, block_t ctr, block_t tw, block_t k);
      @(posedge clk);
      #stim_delay;
      plaintext = pt;
      counter = ctr;
      tweak = tw;
      key = k;
      start = 1'b1;
   endtask

   task automatic release_start();
      @(posedge clk);
      #stim_delay start = 1'b0;
   endtask

   task automatic wait_for_done();
      int n;
      n = 0;
      @(negedge clk);
      while (!done && n < `DEOXYS_ROUNDS + 4) begin
         @(negedge clk);
         n++;
      end
   endtask

   task automatic run_block(block_t pt, block_t ctr, block_t tw, block_t k);
      launch(pt, ctr, tw, k);
      release_start();
      wait_for_done();
   endtask

   task automatic finish_test(string name);
      int n;
      #1;
      n = total_errors() - errors_before;
      if (n == 0)
         $display("test %-14s ok", name);
      else
         $display("test %-14s %0d errors", name, n);
      tests_run++;
      errors_before = total_errors();
   endtask

   initial begin
      block_t pt;
      block_t ctr;
      block_t tw;
      block_t k;
      block_t c1;
      block_t c2;
      int     bit_pos;
      rst_n = 1'b0;
      start = 1'b0;
      plaintext = '0;
      counter = '0;
      tweak = '0;
      key = '0;

      apply_reset();
      @(negedge clk);
      finish_test("reset");

      for (int i = 0; i < 40; i++) begin
         idle_cycles(random_value(2));
         run_block(random_block(), random_block(), random_block(), random_block());
      end
      finish_test("random");

      // Second start lands in the middle of the rounds
      launch(random_block(), random_block(), random_block(), random_block());
      release_start();
      repeat (3) @(posedge clk);
      launch(random_block(), random_block(), random_block(), random_block());
      release_start();
      wait_for_done();
      idle_cycles(2);
      finish_test("ignored start");

      run_block(random_block(), random_block(), random_block(), random_block());
      idle_cycles(10);
      finish_test("held output");

      // Second start is high on the edge that ends the done cycle
      launch(random_block(), random_block(), random_block(), random_block());
      release_start();
      repeat (`DEOXYS_ROUNDS - 1) @(posedge clk);
      launch(random_block(), random_block(), random_block(), random_block());
      release_start();
      wait_for_done();
      finish_test("back-to-back");

      pt = random_block();
      ctr = random_block();
      tw = random_block();
      k = random_block();
      bit_pos = random_value(7);
      run_block(pt, ctr, tw, k);
      c1 = ciphertext;
      run_block(pt, ctr ^ (block_t'(1) << bit_pos), tw, k);
      c2 = ciphertext;
      if (c1 === c2) begin
         tb_errors++;
         $display("t=%0t counters differing in bit %0d gave the same ciphertext", $time,
                  bit_pos);
      end
      finish_test("tweak change");

      idle_cycles(4);
      #1;
      if (blocks_pending != 0) begin
         tb_errors++;
         $display("%0d accepted blocks never finished", blocks_pending);
      end
      if (blocks_checked != num_blocks) begin
         tb_errors++;
         $display("%0d blocks finished where %0d were sent", blocks_checked, num_blocks);
      end
      $display("tests %0d, blocks checked %0d, errors %0d", tests_run, blocks_checked,
               total_errors());
      if (total_errors() == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule

//--- all.f
+incdir+hdl
hdl/deoxys_pkg.sv
hdl/aes_sbox.sv
hdl/deoxys_round.sv
hdl/tweakey_schedule.sv
hdl/deoxys_bc.sv
tests/deoxys_checker.sv
tests/deoxys_props.sv
tests/deoxys_bc_tb.sv
